// ==== Bender.yml ====
package:
  name: cpu_top

sources:
  # Package first, then the RTL in dependency order
  - source/cpu_pkg.sv
  - source/instr_buffer.sv
  - source/decoder.sv
  - source/regfile.sv
  - source/dispatch.sv
  - source/exec_stage.sv
  - source/cpu_top.sv

  - target: simulation
    files:
      - dv/cpu_top_tb.sv

// ==== cpu_top.f ====
source/cpu_pkg.sv
source/instr_buffer.sv
source/decoder.sv
source/regfile.sv
source/dispatch.sv
source/exec_stage.sv
source/cpu_top.sv
dv/cpu_top_tb.sv

// ==== dv/cpu_top_tb.sv ====
`timescale 1ns/1ps

module cpu_top_tb;

    localparam int DIR_GROUPS     = 7;
    localparam int RAND_GROUPS    = 64;
    localparam int BURST_GROUPS   = 48;
    localparam int NUM_GROUPS     = DIR_GROUPS + RAND_GROUPS + BURST_GROUPS;
    localparam int TIMEOUT_CYCLES = NUM_GROUPS * 2 * 4 + 100;

    logic                                               clk;
    logic                                               rst;
    logic                                               fetch_valid_i;
    logic [cpu_pkg::XLEN-1:0]                           fetch_pc_i;
    logic [cpu_pkg::FETCH_WIDTH-1:0][cpu_pkg::XLEN-1:0] fetch_instr_i;
    logic                                               fetch_ready_o;
    logic                                               wb_valid_o;
    logic [cpu_pkg::XLEN-1:0]                           wb_pc_o;
    logic                                               wb_rf_we_o;
    logic [cpu_pkg::REG_ADDR_W-1:0]                     wb_rf_wnum_o;
    logic [cpu_pkg::XLEN-1:0]                           wb_rf_wdata_o;

    logic [31:0] lcg_state = 32'h43b30aff;
    logic [31:0] group_pc  = 32'h1c000000;
    logic [31:0] model_regs [cpu_pkg::NUM_REGS];
    logic [31:0] exp_pc_q [$];
    logic [31:0] exp_instr_q [$];
    logic        saw_stall = 1'b0;   // fetch_ready_o low while a group was offered
    int          cycle_count = 0;

    cpu_top #(
        .IB_DEPTH(8)
    ) i_cpu_top (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid_i(fetch_valid_i),
        .fetch_pc_i   (fetch_pc_i),
        .fetch_instr_i(fetch_instr_i),
        .fetch_ready_o(fetch_ready_o),
        .wb_valid_o   (wb_valid_o),
        .wb_pc_o      (wb_pc_o),
        .wb_rf_we_o   (wb_rf_we_o),
        .wb_rf_wnum_o (wb_rf_wnum_o),
        .wb_rf_wdata_o(wb_rf_wdata_o)
    );

    always #50 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_3r(input logic [16:0] opc, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk);
        return {opc, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rj,
                                             input logic [11:0] si12);
        return {cpu_pkg::OPC_ADDI_W, si12, rj, rd};
    endfunction

    function automatic logic [31:0] enc_lu12i(input logic [4:0] rd, input logic [19:0] si20);
        return {cpu_pkg::OPC_LU12I_W, si20, rd};
    endfunction

    // Mostly r0..r3 so that dependencies stay dense
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = next_rand();
        if (r[31:30] != 2'b00) begin
            return 5'(r[29:28]);
        end
        return r[27:23];
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        r  = next_rand();
        rd = pick_reg();
        rj = pick_reg();
        rk = pick_reg();
        case (r[31:28])
            4'd0, 4'd1:               return enc_3r(cpu_pkg::OPC_ADD_W, rd, rj, rk);
            4'd2, 4'd3:               return enc_3r(cpu_pkg::OPC_SUB_W, rd, rj, rk);
            4'd4:                     return enc_3r(cpu_pkg::OPC_AND, rd, rj, rk);
            4'd5, 4'd14:              return enc_3r(cpu_pkg::OPC_OR, rd, rj, rk);
            4'd6, 4'd7:               return enc_3r(cpu_pkg::OPC_XOR, rd, rj, rk);
            4'd8, 4'd9, 4'd10, 4'd11: return enc_addi(rd, rj, r[19:8]);
            4'd12, 4'd13:             return enc_lu12i(rd, r[23:4]);
            default:                  return {8'hff, r[23:0]};   // Matches no opcode
        endcase
    endfunction

    // Expected commit for one word and its model register update
    function automatic void ref_model(input logic [31:0] word, output logic we,
                                      output logic [4:0] num, output logic [31:0] data);
        cpu_pkg::instr_word_u iw;
        logic [31:0]          a;
        logic [31:0]          b;
        iw   = word;
        num  = iw.fmt_3r.rd;
        a    = model_regs[iw.fmt_3r.rj];
        b    = model_regs[iw.fmt_3r.rk];
        we   = 1'b1;
        data = '0;
        if (iw.fmt_3r.opcode == cpu_pkg::OPC_ADD_W) data = a + b;
        else if (iw.fmt_3r.opcode == cpu_pkg::OPC_SUB_W) data = a - b;
        else if (iw.fmt_3r.opcode == cpu_pkg::OPC_AND) data = a & b;
        else if (iw.fmt_3r.opcode == cpu_pkg::OPC_OR) data = a | b;
        else if (iw.fmt_3r.opcode == cpu_pkg::OPC_XOR) data = a ^ b;
        else if (iw.fmt_2ri12.opcode == cpu_pkg::OPC_ADDI_W)
            data = a + {{20{iw.fmt_2ri12.si12[11]}}, iw.fmt_2ri12.si12};
        else if (iw.fmt_1ri20.opcode == cpu_pkg::OPC_LU12I_W)
            data = {iw.fmt_1ri20.si20, 12'h000};
        else we = 1'b0;
        if (num == 5'd0) we = 1'b0;   // r0 stays zero
        if (we) model_regs[num] = data;
    endfunction

    // Offer one group and hold it until the buffer has room
    task automatic send_group(input logic [31:0] w0, input logic [31:0] w1);
        @(posedge clk);
        fetch_valid_i    <= 1'b1;
        fetch_pc_i       <= group_pc;
        fetch_instr_i[0] <= w0;
        fetch_instr_i[1] <= w1;
        group_pc = group_pc + 32'd8;
        @(negedge clk);
        while (!fetch_ready_o) @(negedge clk);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            fetch_valid_i <= 1'b0;
        end
    endtask

    // A group seen with ready high here transfers at the next rising edge
    always @(negedge clk) begin
        if (!rst && fetch_valid_i) begin
            if (fetch_ready_o) begin
                exp_pc_q.push_back(fetch_pc_i);
                exp_instr_q.push_back(fetch_instr_i[0]);
                exp_pc_q.push_back(fetch_pc_i + 32'd4);
                exp_instr_q.push_back(fetch_instr_i[1]);
            end else begin
                saw_stall = 1'b1;
            end
        end
    end

    always @(negedge clk) begin : check_commits
        logic [31:0] pc;
        logic [31:0] word;
        logic        we;
        logic [4:0]  num;
        logic [31:0] data;
        if (!rst && wb_valid_o) begin
            assert (exp_pc_q.size() != 0)
                else report_failure("A commit appeared with no instruction outstanding");
            pc   = exp_pc_q.pop_front();
            word = exp_instr_q.pop_front();
            ref_model(word, we, num, data);
            assert (wb_pc_o === pc)
                else report_failure($sformatf("Mismatch wb_pc_o: got %08h, expected %08h",
                                              wb_pc_o, pc));
            assert (wb_rf_we_o === we)
                else report_failure($sformatf(
                    "Mismatch wb_rf_we_o: got %0h, expected %0h (pc %08h)",
                    wb_rf_we_o, we, pc));
            if (we) begin
                assert (wb_rf_wnum_o === num)
                    else report_failure($sformatf("Mismatch wb_rf_wnum_o: got %02h, expected %02h",
                                                  wb_rf_wnum_o, num));
                assert (wb_rf_wdata_o === data)
                    else report_failure($sformatf(
                        "Mismatch wb_rf_wdata_o: got %08h, expected %08h (pc %08h)",
                        wb_rf_wdata_o, data, pc));
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure("Commits stopped before all instructions were retired");
        end
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_pc_i    = '0;
        fetch_instr_i = '0;
        for (int i = 0; i < cpu_pkg::NUM_REGS; i++) model_regs[i] = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Quiet pipeline before any fetch
        repeat (3) begin
            @(negedge clk);
            assert (!wb_valid_o && !wb_rf_we_o && fetch_ready_o)
                else report_failure("Outputs not idle after reset");
        end

        // Directed cases for sign extension, shifted si20, wraparound, r0 and unknown words
        send_group(enc_lu12i(5'd1, 20'h80000), enc_addi(5'd2, 5'd0, 12'hfff));
        send_group(enc_3r(cpu_pkg::OPC_ADD_W, 5'd3, 5'd1, 5'd1),
                   enc_3r(cpu_pkg::OPC_SUB_W, 5'd4, 5'd0, 5'd2));
        send_group(enc_addi(5'd5, 5'd2, 12'h7ff), enc_3r(cpu_pkg::OPC_AND, 5'd6, 5'd5, 5'd2));
        send_group(enc_3r(cpu_pkg::OPC_OR, 5'd7, 5'd1, 5'd4),
                   enc_3r(cpu_pkg::OPC_XOR, 5'd8, 5'd7, 5'd2));
        send_group(enc_addi(5'd0, 5'd2, 12'h005), enc_3r(cpu_pkg::OPC_ADD_W, 5'd9, 5'd0, 5'd4));
        send_group(32'hffffffff, enc_lu12i(5'd10, 20'h12345));
        send_group(enc_3r(cpu_pkg::OPC_ADD_W, 5'd11, 5'd2, 5'd4),
                   enc_3r(cpu_pkg::OPC_SUB_W, 5'd12, 5'd0, 5'd1));
        idle(2);

        // Random programs with idle gaps
        for (int g = 0; g < RAND_GROUPS; g++) begin
            logic [31:0] r;
            send_group(random_instr(), random_instr());
            r = next_rand();
            if (r[31:30] == 2'b00) idle(1 + int'(r[29:28]));
        end

        // A group every cycle fills the buffer
        for (int g = 0; g < BURST_GROUPS; g++) begin
            send_group(random_instr(), random_instr());
        end
        idle(1);

        while (exp_pc_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);   // Catch stray commits

        if (saw_stall) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            report_failure("fetch_ready_o never went low while fetch was offered");
        end
    end

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    // Datapath and register file sizes
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;
    localparam int FETCH_WIDTH = 2;   // Words per fetch group

    // 3R format, opcode in bits 31:15
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002a;
    localparam logic [16:0] OPC_XOR   = 17'h0002b;

    // 2RI12 format, opcode in bits 31:22
    localparam logic [9:0] OPC_ADDI_W = 10'h00a;

    // 1RI20 format, opcode in bits 31:25
    localparam logic [6:0] OPC_LU12I_W = 7'h0a;

    typedef enum logic [2:0] {
        ALU_NOP,   // Unrecognized word, no write
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI    // Pass source B through
    } alu_op_e;

    // One instruction word, seen through each encoding format
    typedef union packed {
        struct packed {
            logic [16:0]           opcode;
            logic [REG_ADDR_W-1:0] rk;
            logic [REG_ADDR_W-1:0] rj;
            logic [REG_ADDR_W-1:0] rd;
        } fmt_3r;
        struct packed {
            logic [9:0]            opcode;
            logic [11:0]           si12;
            logic [REG_ADDR_W-1:0] rj;
            logic [REG_ADDR_W-1:0] rd;
        } fmt_2ri12;
        struct packed {
            logic [6:0]            opcode;
            logic [19:0]           si20;
            logic [REG_ADDR_W-1:0] rd;
        } fmt_1ri20;
    } instr_word_u;

endpackage

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
    parameter int IB_DEPTH = 8   // Even, at least 4
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            fetch_valid_i,
    input  logic [cpu_pkg::XLEN-1:0]                        fetch_pc_i,
    input  logic [cpu_pkg::FETCH_WIDTH-1:0][cpu_pkg::XLEN-1:0] fetch_instr_i,
    output logic                                            fetch_ready_o,
    output logic                                            wb_valid_o,
    output logic [cpu_pkg::XLEN-1:0]                        wb_pc_o,
    output logic                                            wb_rf_we_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0]                  wb_rf_wnum_o,
    output logic [cpu_pkg::XLEN-1:0]                        wb_rf_wdata_o
);

    // Buffer head
    logic                     ib_valid;
    logic [cpu_pkg::XLEN-1:0] ib_pc;
    logic [cpu_pkg::XLEN-1:0] ib_instr;

    // Register file read ports
    logic [cpu_pkg::REG_ADDR_W-1:0] rf_raddr_a;
    logic [cpu_pkg::REG_ADDR_W-1:0] rf_raddr_b;
    logic [cpu_pkg::XLEN-1:0]       rf_rdata_a;
    logic [cpu_pkg::XLEN-1:0]       rf_rdata_b;

    // Issue register
    logic                           iss_valid;
    logic [cpu_pkg::XLEN-1:0]       iss_pc;
    cpu_pkg::alu_op_e               iss_op;
    logic [cpu_pkg::REG_ADDR_W-1:0] iss_rd;
    logic                           iss_we;
    logic [cpu_pkg::XLEN-1:0]       iss_src_a;
    logic [cpu_pkg::XLEN-1:0]       iss_src_b;
    logic [cpu_pkg::XLEN-1:0]       ex_result;

    instr_buffer #(
        .IB_DEPTH(IB_DEPTH)
    ) i_instr_buffer (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid_i(fetch_valid_i),
        .fetch_pc_i   (fetch_pc_i),
        .fetch_instr_i(fetch_instr_i),
        .fetch_ready_o(fetch_ready_o),
        .ib_valid_o   (ib_valid),
        .ib_pc_o      (ib_pc),
        .ib_instr_o   (ib_instr)
    );

    dispatch i_dispatch (
        .clk         (clk),
        .rst         (rst),
        .ib_valid_i  (ib_valid),
        .ib_pc_i     (ib_pc),
        .ib_instr_i  (ib_instr),
        .rf_rdata_a_i(rf_rdata_a),
        .rf_rdata_b_i(rf_rdata_b),
        .wb_valid_i  (wb_valid_o),
        .wb_we_i     (wb_rf_we_o),
        .wb_wnum_i   (wb_rf_wnum_o),
        .wb_wdata_i  (wb_rf_wdata_o),
        .ex_result_i (ex_result),
        .rf_raddr_a_o(rf_raddr_a),
        .rf_raddr_b_o(rf_raddr_b),
        .iss_valid_o (iss_valid),
        .iss_pc_o    (iss_pc),
        .iss_op_o    (iss_op),
        .iss_rd_o    (iss_rd),
        .iss_we_o    (iss_we),
        .iss_src_a_o (iss_src_a),
        .iss_src_b_o (iss_src_b)
    );

    exec_stage i_exec_stage (
        .clk          (clk),
        .rst          (rst),
        .iss_valid_i  (iss_valid),
        .iss_pc_i     (iss_pc),
        .iss_op_i     (iss_op),
        .iss_rd_i     (iss_rd),
        .iss_we_i     (iss_we),
        .iss_src_a_i  (iss_src_a),
        .iss_src_b_i  (iss_src_b),
        .ex_result_o  (ex_result),
        .wb_valid_o   (wb_valid_o),
        .wb_pc_o      (wb_pc_o),
        .wb_rf_we_o   (wb_rf_we_o),
        .wb_rf_wnum_o (wb_rf_wnum_o),
        .wb_rf_wdata_o(wb_rf_wdata_o)
    );

    // Written from the commit stage
    regfile i_regfile (
        .clk      (clk),
        .rst      (rst),
        .raddr_a_i(rf_raddr_a),
        .raddr_b_i(rf_raddr_b),
        .we_i     (wb_rf_we_o),
        .waddr_i  (wb_rf_wnum_o),
        .wdata_i  (wb_rf_wdata_o),
        .rdata_a_o(rf_rdata_a),
        .rdata_b_o(rf_rdata_b)
    );

endmodule

// ==== source/decoder.sv ====
`timescale 1ns/1ps

module decoder (
    input  cpu_pkg::instr_word_u             instr_i,
    output cpu_pkg::alu_op_e                 op_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0]   rd_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0]   rj_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0]   rk_o,
    output logic                             use_rk_o,
    output logic [cpu_pkg::XLEN-1:0]         imm_o,
    output logic                             we_o
);

    always_comb begin
        op_o     = cpu_pkg::ALU_NOP;
        rd_o     = instr_i.fmt_3r.rd;   // rd sits in bits 4:0 in every format
        rj_o     = instr_i.fmt_3r.rj;
        rk_o     = instr_i.fmt_3r.rk;
        use_rk_o = 1'b0;
        imm_o    = '0;

        case (instr_i.fmt_3r.opcode)
            cpu_pkg::OPC_ADD_W: begin
                op_o     = cpu_pkg::ALU_ADD;
                use_rk_o = 1'b1;
            end
            cpu_pkg::OPC_SUB_W: begin
                op_o     = cpu_pkg::ALU_SUB;
                use_rk_o = 1'b1;
            end
            cpu_pkg::OPC_AND: begin
                op_o     = cpu_pkg::ALU_AND;
                use_rk_o = 1'b1;
            end
            cpu_pkg::OPC_OR: begin
                op_o     = cpu_pkg::ALU_OR;
                use_rk_o = 1'b1;
            end
            cpu_pkg::OPC_XOR: begin
                op_o     = cpu_pkg::ALU_XOR;
                use_rk_o = 1'b1;
            end
            default: begin
                // Not a 3R op, try the immediate formats
                if (instr_i.fmt_2ri12.opcode == cpu_pkg::OPC_ADDI_W) begin
                    op_o  = cpu_pkg::ALU_ADD;
                    imm_o = {{(cpu_pkg::XLEN - 12){instr_i.fmt_2ri12.si12[11]}},
                             instr_i.fmt_2ri12.si12};
                end else if (instr_i.fmt_1ri20.opcode == cpu_pkg::OPC_LU12I_W) begin
                    op_o  = cpu_pkg::ALU_LUI;
                    rj_o  = '0;   // No register source
                    imm_o = {instr_i.fmt_1ri20.si20, 12'b0};
                end
            end
        endcase
    end

    // Writes to r0 are dropped here
    assign we_o = (op_o != cpu_pkg::ALU_NOP) && (rd_o != '0);

endmodule

// ==== source/dispatch.sv ====
`timescale 1ns/1ps

module dispatch (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           ib_valid_i,
    input  logic [cpu_pkg::XLEN-1:0]       ib_pc_i,
    input  logic [cpu_pkg::XLEN-1:0]       ib_instr_i,
    input  logic [cpu_pkg::XLEN-1:0]       rf_rdata_a_i,
    input  logic [cpu_pkg::XLEN-1:0]       rf_rdata_b_i,
    input  logic                           wb_valid_i,
    input  logic                           wb_we_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] wb_wnum_i,
    input  logic [cpu_pkg::XLEN-1:0]       wb_wdata_i,
    input  logic [cpu_pkg::XLEN-1:0]       ex_result_i,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rf_raddr_a_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rf_raddr_b_o,
    output logic                           iss_valid_o,
    output logic [cpu_pkg::XLEN-1:0]       iss_pc_o,
    output cpu_pkg::alu_op_e               iss_op_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] iss_rd_o,
    output logic                           iss_we_o,
    output logic [cpu_pkg::XLEN-1:0]       iss_src_a_o,
    output logic [cpu_pkg::XLEN-1:0]       iss_src_b_o
);

    cpu_pkg::alu_op_e               dec_op;
    logic [cpu_pkg::REG_ADDR_W-1:0] dec_rd;
    logic [cpu_pkg::REG_ADDR_W-1:0] dec_rj;
    logic [cpu_pkg::REG_ADDR_W-1:0] dec_rk;
    logic                           dec_use_rk;
    logic [cpu_pkg::XLEN-1:0]       dec_imm;
    logic                           dec_we;

    logic [cpu_pkg::XLEN-1:0] src_a;
    logic [cpu_pkg::XLEN-1:0] src_b;

    decoder i_decoder (
        .instr_i (ib_instr_i),
        .op_o    (dec_op),
        .rd_o    (dec_rd),
        .rj_o    (dec_rj),
        .rk_o    (dec_rk),
        .use_rk_o(dec_use_rk),
        .imm_o   (dec_imm),
        .we_o    (dec_we)
    );

    assign rf_raddr_a_o = dec_rj;
    assign rf_raddr_b_o = dec_rk;

    // Youngest producer wins, issue stage before commit stage before the file
    always_comb begin
        src_a = rf_rdata_a_i;
        if (iss_valid_o && iss_we_o && (iss_rd_o == dec_rj) && (dec_rj != '0)) begin
            src_a = ex_result_i;
        end else if (wb_valid_i && wb_we_i && (wb_wnum_i == dec_rj) && (dec_rj != '0)) begin
            src_a = wb_wdata_i;
        end
    end

    always_comb begin
        src_b = rf_rdata_b_i;
        if (!dec_use_rk) begin
            src_b = dec_imm;   // Immediate formats have no rk
        end else if (iss_valid_o && iss_we_o && (iss_rd_o == dec_rk) && (dec_rk != '0)) begin
            src_b = ex_result_i;
        end else if (wb_valid_i && wb_we_i && (wb_wnum_i == dec_rk) && (dec_rk != '0)) begin
            src_b = wb_wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            iss_valid_o <= 1'b0;
        end else begin
            iss_valid_o <= ib_valid_i;
        end
    end

    // Payload only moves with a real instruction
    always_ff @(posedge clk) begin
        if (ib_valid_i) begin
            iss_pc_o    <= ib_pc_i;
            iss_op_o    <= dec_op;
            iss_rd_o    <= dec_rd;
            iss_we_o    <= dec_we;
            iss_src_a_o <= src_a;
            iss_src_b_o <= src_b;
        end
    end

endmodule

// ==== source/exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           iss_valid_i,
    input  logic [cpu_pkg::XLEN-1:0]       iss_pc_i,
    input  cpu_pkg::alu_op_e               iss_op_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] iss_rd_i,
    input  logic                           iss_we_i,
    input  logic [cpu_pkg::XLEN-1:0]       iss_src_a_i,
    input  logic [cpu_pkg::XLEN-1:0]       iss_src_b_i,
    output logic [cpu_pkg::XLEN-1:0]       ex_result_o,
    output logic                           wb_valid_o,
    output logic [cpu_pkg::XLEN-1:0]       wb_pc_o,
    output logic                           wb_rf_we_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] wb_rf_wnum_o,
    output logic [cpu_pkg::XLEN-1:0]       wb_rf_wdata_o
);

    // 32-bit wraparound on add and sub
    always_comb begin
        case (iss_op_i)
            cpu_pkg::ALU_ADD: ex_result_o = iss_src_a_i + iss_src_b_i;
            cpu_pkg::ALU_SUB: ex_result_o = iss_src_a_i - iss_src_b_i;
            cpu_pkg::ALU_AND: ex_result_o = iss_src_a_i & iss_src_b_i;
            cpu_pkg::ALU_OR:  ex_result_o = iss_src_a_i | iss_src_b_i;
            cpu_pkg::ALU_XOR: ex_result_o = iss_src_a_i ^ iss_src_b_i;
            cpu_pkg::ALU_LUI: ex_result_o = iss_src_b_i;   // Already shifted by decode
            default:          ex_result_o = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
            wb_rf_we_o <= 1'b0;
        end else begin
            wb_valid_o <= iss_valid_i;
            wb_rf_we_o <= iss_valid_i && iss_we_i;
        end
    end

    // Commit payload, also the register file write
    always_ff @(posedge clk) begin
        if (iss_valid_i) begin
            wb_pc_o       <= iss_pc_i;
            wb_rf_wnum_o  <= iss_rd_i;
            wb_rf_wdata_o <= ex_result_o;
        end
    end

endmodule

// ==== source/instr_buffer.sv ====
`timescale 1ns/1ps

module instr_buffer #(
    parameter int IB_DEPTH = 8
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            fetch_valid_i,
    input  logic [cpu_pkg::XLEN-1:0]                        fetch_pc_i,
    input  logic [cpu_pkg::FETCH_WIDTH-1:0][cpu_pkg::XLEN-1:0] fetch_instr_i,
    output logic                                            fetch_ready_o,
    output logic                                            ib_valid_o,
    output logic [cpu_pkg::XLEN-1:0]                        ib_pc_o,
    output logic [cpu_pkg::XLEN-1:0]                        ib_instr_o
);

    localparam int PTR_W = $clog2(IB_DEPTH);
    localparam int CNT_W = $clog2(IB_DEPTH + 1);

    logic [cpu_pkg::XLEN-1:0] pc_mem    [IB_DEPTH];
    logic [cpu_pkg::XLEN-1:0] instr_mem [IB_DEPTH];

    logic [PTR_W-1:0] wr_ptr;   // Always a multiple of FETCH_WIDTH
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;

    // Room for a whole group, occupancy only
    assign fetch_ready_o = (count <= CNT_W'(IB_DEPTH - cpu_pkg::FETCH_WIDTH));
    assign push          = fetch_valid_i && fetch_ready_o;
    assign pop           = (count != '0);   // Dispatch takes the head every cycle

    assign ib_valid_o = pop;
    assign ib_pc_o    = pc_mem[rd_ptr];
    assign ib_instr_o = instr_mem[rd_ptr];

    // Group storage, word i goes to wr_ptr + i without wrapping
    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < cpu_pkg::FETCH_WIDTH; i++) begin
                instr_mem[wr_ptr + PTR_W'(i)] <= fetch_instr_i[i];
                pc_mem[wr_ptr + PTR_W'(i)]    <= fetch_pc_i + cpu_pkg::XLEN'(4 * i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == PTR_W'(IB_DEPTH - cpu_pkg::FETCH_WIDTH)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + PTR_W'(cpu_pkg::FETCH_WIDTH);
                end
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(IB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Net change is +2, +1, -1 or 0
            count <= count + (push ? CNT_W'(cpu_pkg::FETCH_WIDTH) : '0) - CNT_W'(pop);
        end
    end

endmodule

// ==== source/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr_a_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr_b_i,
    input  logic                           we_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [cpu_pkg::XLEN-1:0]       wdata_i,
    output logic [cpu_pkg::XLEN-1:0]       rdata_a_o,
    output logic [cpu_pkg::XLEN-1:0]       rdata_b_o
);

    logic [cpu_pkg::XLEN-1:0] regs [cpu_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;   // r0 is never written, stays zero
        end
    end

    // Combinational reads, dispatch forwards the in-flight writes
    assign rdata_a_o = regs[raddr_a_i];
    assign rdata_b_o = regs[raddr_b_i];

endmodule
